/* Makefile */
sim:
	verilator --binary --timing --top-module tb_arcade_inputs -f arcade_inputs.f
	./obj_dir/Vtb_arcade_inputs

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* arcade_inputs.f */
input_pkg.sv
game_pkg.sv
ps2_key_decoder.sv
player_control.sv
game_config_loader.sv
input_port_mapper.sv
arcade_inputs.sv
tb_arcade_inputs.sv

/* arcade_inputs.sv */
// Player input path of the arcade core: keyboard and joysticks to cabinet input ports
`default_nettype none
`timescale 1ns/1ps

module arcade_inputs (
	input  wire logic                                              clk_sys,
	input  wire logic                                              rst_n,
	input  wire logic [10:0]                                       ps_key,
	input  wire input_pkg::joy_word_t [input_pkg::num_players-1:0] joy,
	input  wire logic                                              dl_wr,
	input  wire game_pkg::dl_index_t                               dl_index,
	input  wire game_pkg::dl_addr_t                                dl_addr,
	input  wire game_pkg::port_byte_t                              dl_data,
	input  wire logic                                              fire_mode,
	output game_pkg::port_byte_t                                   port_a,
	output game_pkg::port_byte_t                                   port_b,
	output game_pkg::port_byte_t                                   port_c,
	output game_pkg::port_byte_t                                   port_d,
	output game_pkg::hw_sel_t                                      hw_sel
);

	import input_pkg::*;
	import game_pkg::*;

	key_event_t                     key_event;
	player_ctrl_t [num_players-1:0] players;
	game_id_e                       game_id;
	dip_bank_t                      dip_bank;

	ps2_key_decoder u_ps2_key_decoder (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ps_key    (ps_key),
		.key_event (key_event)
	);

	// ========================================
	// Player units
	// ========================================
	for (genvar p = 0; p < num_players; p++)
	begin : g_player
		player_control #(
			.player_index (p)
		) u_player_control (
			.clk_sys   (clk_sys),
			.rst_n     (rst_n),
			.key_event (key_event), // Same event, each unit checks its own keys
			.joy       (joy[p]),
			.ctrl      (players[p])
		);
	end

	game_config_loader u_game_config_loader (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.game_id  (game_id),
		.dip_bank (dip_bank)
	);

	input_port_mapper u_input_port_mapper (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.players   (players),
		.game_id   (game_id),
		.dip_bank  (dip_bank),
		.fire_mode (fire_mode),
		.port_a    (port_a),
		.port_b    (port_b),
		.port_c    (port_c),
		.port_d    (port_d),
		.hw_sel    (hw_sel)
	);

endmodule

`default_nettype wire

/* arcade_inputs_input.txt */
# kind arg_1 arg_2 arg_3 then expected port_a port_b port_c port_d hw_sel, all hex
# kind 0 idle, 1 key code pressed, 2 joy player word, 3 download index addr data, 4 fire_mode
0 0 0 0 FF FF FF FF 00
1 175 1 0 FE FF EF FF 00
1 014 1 0 F6 F7 EF FF 00
1 005 1 0 F6 77 EF FF 00
1 06B 1 0 D6 57 EF FF 00
1 0FF 1 0 D6 57 EF FF 00
1 11C 1 0 D6 57 EF FF 00
1 175 0 0 D7 57 FF FF 00
1 014 0 0 DF 5F FF FF 00
1 005 0 0 DF DF FF FF 00
1 16B 0 0 FF FF FF FF 00
1 02D 1 0 FE FF EF FF 00
2 0 008 0 FE FF EF FF 00
1 02D 0 0 FE FF EF FF 00
2 0 000 0 FF FF FF FF 00
2 1 410 0 77 F7 FF FF 00
1 01C 1 0 77 F7 FF FF 00
2 1 000 0 F7 F7 FF FF 00
1 01C 0 0 FF FF FF FF 00
2 0 23A 0 D4 93 EF FF 00
3 01 0 02 D4 93 EF FF 01
3 01 0 04 D8 FF BF FF 02
3 01 0 08 DA DB FE FF 03
3 01 0 0B DA E7 FF FF 07
4 1 0 0 DA 9B FF FF 07
3 01 0 0D D6 97 6F 7F 0A
4 0 0 0 DA 9B CF DF 0A
3 01 0 06 D4 93 EF FF 00
3 01 0 2A D4 93 EF FF 00
3 FE 0 0F 04 93 EF FF 00
3 FE 1 F0 04 90 EF FF 00
3 FE 2 55 04 90 45 FF 00
3 FE 3 3C 04 90 45 3C 00
3 FE 8 00 04 90 45 3C 00
3 02 0 00 04 90 45 3C 00
2 0 000 0 0F F0 55 3C 00

/* game_config_loader.sv */
// Picks the game id and DIP switch bytes out of the download stream
`default_nettype none
`timescale 1ns/1ps

module game_config_loader (
	input  wire logic                 clk_sys,
	input  wire logic                 rst_n,
	input  wire logic                 dl_wr,
	input  wire game_pkg::dl_index_t  dl_index,
	input  wire game_pkg::dl_addr_t   dl_addr,
	input  wire game_pkg::port_byte_t dl_data,
	output game_pkg::game_id_e        game_id,
	output game_pkg::dip_bank_t       dip_bank
);

	import game_pkg::*;

	logic game_wr;
	logic dip_wr;

	assign game_wr = dl_wr && (dl_index == dl_index_game);
	// Only the first eight bytes of the DIP image are switches
	assign dip_wr  = dl_wr && (dl_index == dl_index_dip) &&
		(dl_addr < dl_addr_t'(num_dip_bytes));

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			game_id <= game_scramble;
		end
		else if (game_wr)
		begin
			game_id <= game_id_e'(dl_data); // Unknown ids fall to the default layout
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			dip_bank <= {num_dip_bytes{port_released}};
		end
		else if (dip_wr)
		begin
			dip_bank[dl_addr[dip_addr_bits-1:0]] <= dl_data;
		end
	end

endmodule

`default_nettype wire

/* game_pkg.sv */
// Game ids, download stream types and hardware select codes for the cabinet input ports
`default_nettype none

package game_pkg;

	typedef enum logic [7:0] {
		game_scramble = 8'd0,
		game_amidar   = 8'd1,
		game_frogger  = 8'd2,
		game_scobra   = 8'd3,
		game_tazman   = 8'd4,
		game_armorcar = 8'd5,
		game_moonwar  = 8'd6,
		game_spdcoin  = 8'd7,
		game_calipso  = 8'd8,
		game_darkplnt = 8'd9,
		game_anteater = 8'd10,
		game_losttomb = 8'd11,
		game_theend   = 8'd12,
		game_mars     = 8'd13,
		game_stratgyx = 8'd14,
		game_turtles  = 8'd15,
		game_minefld  = 8'd16,
		game_rescue   = 8'd17,
		game_mimonkey = 8'd18
	} game_id_e;

	typedef logic [7:0]  port_byte_t; // Active low
	typedef logic [7:0]  hw_sel_t;
	typedef logic [7:0]  dl_index_t;
	typedef logic [24:0] dl_addr_t;

	localparam port_byte_t port_released = 8'hFF;

	// ========================================
	// Download stream
	// ========================================
	localparam dl_index_t dl_index_game = 8'd1;
	localparam dl_index_t dl_index_dip  = 8'd254;

	localparam int num_dip_bytes = 8;
	localparam int dip_addr_bits = $clog2(num_dip_bytes);

	typedef port_byte_t [num_dip_bytes-1:0] dip_bank_t;

	// Board variant per game
	localparam hw_sel_t hw_sel_default  = 8'd0;
	localparam hw_sel_t hw_sel_frogger  = 8'd1;
	localparam hw_sel_t hw_sel_tazman   = 8'd2;
	localparam hw_sel_t hw_sel_calipso  = 8'd3;
	localparam hw_sel_t hw_sel_losttomb = 8'd7;
	localparam hw_sel_t hw_sel_mars     = 8'd10;

endpackage

`default_nettype wire

/* input_pkg.sv */
// Player control types, joystick bit map and keyboard tables shared by the input path
`default_nettype none

package input_pkg;

	localparam int num_players = 2;

	typedef logic [8:0]  scan_code_t; // Extended flag plus PS/2 code
	typedef logic [31:0] joy_word_t;

	// Positions inside the PS/2 key word
	localparam int ps_toggle_bit  = 10;
	localparam int ps_pressed_bit = 9;

	// ========================================
	// USB joystick word
	// ========================================
	localparam int joy_right   = 0;
	localparam int joy_left    = 1;
	localparam int joy_down    = 2;
	localparam int joy_up      = 3;
	localparam int joy_fire_a  = 4;
	localparam int joy_fire_b  = 5;
	localparam int joy_fire_c  = 6;
	localparam int joy_fire_d  = 7;
	localparam int joy_fire_e  = 8;
	localparam int joy_start_1 = 8; // Shares the bit with fire e
	localparam int joy_start_2 = 9;
	localparam int joy_coin    = 10;

	typedef struct packed {
		logic       up;
		logic       down;
		logic       left;
		logic       right;
		logic [4:0] fire;    // Bit 0 is fire a
		logic       start_1;
		logic       start_2;
		logic       coin;
	} player_ctrl_t;

	typedef struct packed {
		logic       strobe;
		logic       pressed;
		scan_code_t code;
	} key_event_t;

	// ========================================
	// Keyboard tables
	// ========================================
	// One entry drives the controls set in target
	typedef struct packed {
		scan_code_t   code;
		logic         any_ext; // Match ignoring the extended flag
		player_ctrl_t target;
	} key_entry_t;

	localparam int key_table_len = 11;

	localparam player_ctrl_t sel_up      = '{up: 1'b1, default: '0};
	localparam player_ctrl_t sel_down    = '{down: 1'b1, default: '0};
	localparam player_ctrl_t sel_left    = '{left: 1'b1, default: '0};
	localparam player_ctrl_t sel_right   = '{right: 1'b1, default: '0};
	localparam player_ctrl_t sel_fire_a  = '{fire: 5'b00001, default: '0};
	localparam player_ctrl_t sel_fire_b  = '{fire: 5'b00010, default: '0};
	localparam player_ctrl_t sel_start_1 = '{start_1: 1'b1, default: '0};
	localparam player_ctrl_t sel_start_2 = '{start_2: 1'b1, default: '0};
	localparam player_ctrl_t sel_coin    = '{coin: 1'b1, default: '0};

	localparam key_entry_t key_none = '{code: '0, any_ext: 1'b0, target: '0};

	localparam key_entry_t key_tables [num_players][key_table_len] = '{
		'{
			'{9'h075, 1'b1, sel_up},      // Arrows
			'{9'h072, 1'b1, sel_down},
			'{9'h06B, 1'b1, sel_left},
			'{9'h074, 1'b1, sel_right},
			'{9'h014, 1'b0, sel_fire_a},  // Ctrl
			'{9'h029, 1'b0, sel_fire_b},  // Space
			'{9'h005, 1'b0, sel_start_1}, // F1
			'{9'h016, 1'b0, sel_start_1}, // 1
			'{9'h006, 1'b0, sel_start_2}, // F2
			'{9'h01E, 1'b0, sel_start_2}, // 2
			'{9'h02E, 1'b0, sel_coin}     // 5
		},
		'{
			'{9'h02D, 1'b0, sel_up},      // R
			'{9'h02B, 1'b0, sel_down},    // F
			'{9'h023, 1'b0, sel_left},    // D
			'{9'h034, 1'b0, sel_right},   // G
			'{9'h01C, 1'b0, sel_fire_a},  // A
			'{9'h01B, 1'b0, sel_fire_b},  // S
			'{9'h036, 1'b0, sel_coin},    // 6
			key_none,
			key_none,
			key_none,
			key_none
		}
	};

endpackage

`default_nettype wire

/* input_port_mapper.sv */
// Builds the four active-low cabinet input bytes and the board select for the loaded game
`default_nettype none
`timescale 1ns/1ps

module input_port_mapper (
	input  wire logic                                                clk_sys,
	input  wire logic                                                rst_n,
	input  wire input_pkg::player_ctrl_t [input_pkg::num_players-1:0] players,
	input  wire game_pkg::game_id_e                                  game_id,
	input  wire game_pkg::dip_bank_t                                 dip_bank,
	input  wire logic                                                fire_mode,
	output game_pkg::port_byte_t                                     port_a,
	output game_pkg::port_byte_t                                     port_b,
	output game_pkg::port_byte_t                                     port_c,
	output game_pkg::port_byte_t                                     port_d,
	output game_pkg::hw_sel_t                                        hw_sel
);

	import input_pkg::*;
	import game_pkg::*;

	player_ctrl_t merged;
	logic         up;
	logic         down;
	logic         left;
	logic         right;
	logic         fire_a;
	logic         fire_b;
	logic         fire_c;
	logic         fire_d;
	logic         fire_e;
	logic         start_1;
	logic         start_2;
	logic         coin;
	port_byte_t   layout_a;
	port_byte_t   layout_b;
	port_byte_t   layout_c;
	port_byte_t   layout_d;
	hw_sel_t      hw_next;

	// Both players drive the same cabinet controls
	always_comb
	begin
		merged = '0;
		for (int p = 0; p < num_players; p++)
		begin
			merged = merged | players[p];
		end
	end

	assign up      = merged.up;
	assign down    = merged.down;
	assign left    = merged.left;
	assign right   = merged.right;
	assign fire_a  = merged.fire[0];
	assign fire_b  = merged.fire[1];
	assign fire_c  = merged.fire[2];
	assign fire_d  = merged.fire[3];
	assign fire_e  = merged.fire[4];
	assign start_1 = merged.start_1;
	assign start_2 = merged.start_2;
	assign coin    = merged.coin;

	// ========================================
	// Per-game layouts
	// ========================================
	always_comb
	begin
		hw_next  = hw_sel_default;
		layout_a = ~{coin, 1'b0, left, right, fire_a, 1'b0, fire_b, up};
		layout_b = ~{start_1, start_2, left, right, fire_a, fire_b, 2'b00};
		layout_c = ~{1'b0, down, 1'b0, up, 3'b000, down};
		layout_d = port_released;

		case (game_id)
			game_frogger:
			begin
				hw_next = hw_sel_frogger; // Scramble layout on its own board
			end
			game_tazman:
			begin
				hw_next  = hw_sel_tazman;
				layout_a = ~{coin, 1'b0, left, right, down, up, fire_a, fire_b};
				layout_b = port_released;
				layout_c = ~{1'b0, start_2, 2'b00, 3'b000, start_1};
			end
			game_calipso:
			begin
				hw_next  = hw_sel_calipso;
				layout_a = ~{coin, 1'b0, left, right, down, up, 1'b0, start_2 | fire_a};
				layout_b = ~{1'b0, 1'b0, left, right, down, up, 1'b0, 1'b0};
				layout_c = ~{5'b00000, 2'b00, fire_a | start_1};
			end
			game_losttomb:
			begin
				hw_next  = hw_sel_losttomb;
				layout_a = ~{coin, 1'b0, left, right, down, up, start_1, start_2};
				// Second stick either fires or moves
				layout_b = fire_mode ?
					~{1'b0, fire_e | fire_a, left, right, down, up, 2'b00} :
					~{1'b0, fire_e, fire_d, fire_a, fire_b, fire_c, 2'b00};
				layout_c = port_released;
			end
			game_mars:
			begin
				hw_next = hw_sel_mars;
				if (fire_mode)
				begin
					layout_a = ~{coin, 1'b0, left, right, left, right, 1'b0, up};
					layout_b = ~{start_1, start_2, left, right, left, right, 2'b00};
					layout_c = ~{up, down, down, up, 3'b000, down};
					layout_d = ~{up, 1'b0, down, 5'b00000};
				end
				else
				begin
					layout_a = ~{coin, 1'b0, left, right, fire_d, fire_a, 1'b0, up};
					layout_b = ~{start_1, start_2, left, right, fire_d, fire_a, 2'b00};
					layout_c = ~{fire_c, down, fire_b, up, 3'b000, down};
					layout_d = ~{fire_c, 1'b0, fire_b, 5'b00000};
				end
			end
			default:
			begin
				hw_next = hw_sel_default; // Scramble and unlisted ids
			end
		endcase
	end

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			port_a <= port_released;
			port_b <= port_released;
			port_c <= port_released;
			port_d <= port_released;
			hw_sel <= hw_sel_default;
		end
		else
		begin
			port_a <= layout_a & dip_bank[0]; // DIP bytes pull bits low
			port_b <= layout_b & dip_bank[1];
			port_c <= layout_c & dip_bank[2];
			port_d <= layout_d & dip_bank[3];
			hw_sel <= hw_next;
		end
	end

endmodule

`default_nettype wire

/* player_control.sv */
// Per-player key latches merged with the USB joystick; one instance per player
`default_nettype none
`timescale 1ns/1ps

module player_control #(
	parameter int player_index = 0
) (
	input  wire logic                    clk_sys,
	input  wire logic                    rst_n,
	input  wire input_pkg::key_event_t   key_event,
	input  wire input_pkg::joy_word_t    joy,
	output input_pkg::player_ctrl_t      ctrl
);

	import input_pkg::*;

	player_ctrl_t latch_q;
	player_ctrl_t latch_next;
	player_ctrl_t joy_ctrl;

	// ========================================
	// Key table lookup
	// ========================================
	always_comb
	begin
		key_entry_t entry;
		logic       hit;

		latch_next = latch_q;
		entry      = key_none;
		hit        = 1'b0;
		if (key_event.strobe)
		begin
			for (int i = 0; i < key_table_len; i++)
			begin
				entry = key_tables[player_index][i];
				hit   = (entry.target != '0) &&
					(entry.any_ext ? (key_event.code[7:0] == entry.code[7:0])
						: (key_event.code == entry.code));
				if (hit)
				begin
					latch_next = key_event.pressed ? (latch_next | entry.target)
						: (latch_next & ~entry.target);
				end
			end
		end
	end

	assign joy_ctrl = '{
		up:      joy[joy_up],
		down:    joy[joy_down],
		left:    joy[joy_left],
		right:   joy[joy_right],
		fire:    {joy[joy_fire_e], joy[joy_fire_d], joy[joy_fire_c],
			joy[joy_fire_b], joy[joy_fire_a]},
		start_1: joy[joy_start_1],
		start_2: joy[joy_start_2],
		coin:    joy[joy_coin]
	};

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			latch_q <= '0;
			ctrl    <= '0;
		end
		else
		begin
			latch_q <= latch_next;
			ctrl    <= latch_q | joy_ctrl; // Either source holds a control
		end
	end

endmodule

`default_nettype wire

/* ps2_key_decoder.sv */
// Turns each toggle of the PS/2 key word into a one-cycle key event strobe
`default_nettype none
`timescale 1ns/1ps

module ps2_key_decoder (
	input  wire logic              clk_sys,
	input  wire logic              rst_n,
	input  wire logic [10:0]       ps_key,
	output input_pkg::key_event_t  key_event
);

	import input_pkg::*;

	logic       toggle_q;
	logic       key_change;
	logic       strobe_q;
	logic       pressed_q;
	scan_code_t code_q;

	assign key_change = toggle_q != ps_key[ps_toggle_bit];

	// Last seen toggle bit
	always_ff @(posedge clk_sys)
	begin
		toggle_q <= ps_key[ps_toggle_bit];
	end

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			strobe_q <= 1'b0;
		end
		else
		begin
			strobe_q <= key_change; // High for one cycle per event
		end
	end

	// Key payload, held until the next event
	always_ff @(posedge clk_sys)
	begin
		if (key_change)
		begin
			code_q    <= ps_key[8:0];
			pressed_q <= ps_key[ps_pressed_bit];
		end
	end

	assign key_event = '{strobe: strobe_q, pressed: pressed_q, code: code_q};

endmodule

`default_nettype wire

/* tb_arcade_inputs.sv */
// Self-checking testbench that plays the vector file through the arcade input path
`default_nettype none
`timescale 1ns/1ps

module tb_arcade_inputs;

	import input_pkg::*;
	import game_pkg::*;

	localparam int reset_cycles  = 16;
	localparam int settle_cycles = 8;  // Covers the longest keyboard path
	localparam int max_steps     = 500;

	logic                        clk_sys;
	logic                        rst_n;
	logic [10:0]                 ps_key;
	joy_word_t [num_players-1:0] joy;
	logic                        dl_wr;
	dl_index_t                   dl_index;
	dl_addr_t                    dl_addr;
	port_byte_t                  dl_data;
	logic                        fire_mode;
	port_byte_t                  port_a;
	port_byte_t                  port_b;
	port_byte_t                  port_c;
	port_byte_t                  port_d;
	hw_sel_t                     hw_sel;

	logic key_toggle; // Flips once per key event
	int   step;

	arcade_inputs u_arcade_inputs (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ps_key    (ps_key),
		.joy       (joy),
		.dl_wr     (dl_wr),
		.dl_index  (dl_index),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.fire_mode (fire_mode),
		.port_a    (port_a),
		.port_b    (port_b),
		.port_c    (port_c),
		.port_d    (port_d),
		.hw_sel    (hw_sel)
	);

	always #10 clk_sys = ~clk_sys;

	// ========================================
	// Helpers
	// ========================================
	// Bounded by its count, ends on a falling edge
	task automatic wait_cycles(input int count);
		int done;

		done = 0;
		while (done < count)
		begin
			@(negedge clk_sys);
			done++;
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Fail at %0d ns: step %0d %s is %h, expected %h",
				$time, step, name, actual, expected);
			$display("Errors found");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	// Drives one vector line; all changes land on a falling edge
	task automatic apply_step(input logic [31:0] kind, input logic [31:0] arg_1,
		input logic [31:0] arg_2, input logic [31:0] arg_3);
		case (kind)
			32'd0:
			begin
				// Idle, only checks
			end
			32'd1:
			begin
				key_toggle = ~key_toggle;
				ps_key     = {key_toggle, arg_2[0], arg_1[8:0]};
			end
			32'd2:
			begin
				joy[arg_1[0]] = arg_2;
			end
			32'd3:
			begin
				dl_index = arg_1[7:0];
				dl_addr  = arg_2[24:0];
				dl_data  = arg_3[7:0];
				dl_wr    = 1'b1;
				wait_cycles(1); // Single write cycle
				dl_wr    = 1'b0;
			end
			32'd4:
			begin
				fire_mode = arg_1[0];
			end
			default:
			begin
				$display("Errors found");
				$fatal(1, "Vector line %0d has an unknown step kind %0d", step, kind);
			end
		endcase
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial
	begin
		int          fd;
		int          fields;
		string       line;
		logic [31:0] kind;
		logic [31:0] arg_1;
		logic [31:0] arg_2;
		logic [31:0] arg_3;
		logic [31:0] exp_a;
		logic [31:0] exp_b;
		logic [31:0] exp_c;
		logic [31:0] exp_d;
		logic [31:0] exp_hw;

		clk_sys    = 1'b0;
		rst_n      = 1'b0;
		ps_key     = '0;
		joy        = '0;
		dl_wr      = 1'b0;
		dl_index   = '0;
		dl_addr    = '0;
		dl_data    = '0;
		fire_mode  = 1'b0;
		key_toggle = 1'b0;
		step       = 0;

		fd = $fopen("arcade_inputs_input.txt", "r");
		if (fd == 0)
		begin
			$display("Errors found");
			$fatal(1, "Cannot open the vector file arcade_inputs_input.txt");
		end

		wait_cycles(reset_cycles);
		rst_n = 1'b1;

		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.getc(0) != 8'h23) // Skips blanks and comments
			begin
				step++;
				if (step > max_steps)
				begin
					$display("Errors found");
					$fatal(1, "The vector file has more than %0d steps", max_steps);
				end
				fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h", kind, arg_1, arg_2,
					arg_3, exp_a, exp_b, exp_c, exp_d, exp_hw);
				if (fields != 9)
				begin
					$display("Errors found");
					$fatal(1, "Vector line %0d is too short: %s", step, line);
				end
				apply_step(kind, arg_1, arg_2, arg_3);
				wait_cycles(settle_cycles);
				check_value("port_a", 32'(port_a), exp_a);
				check_value("port_b", 32'(port_b), exp_b);
				check_value("port_c", 32'(port_c), exp_c);
				check_value("port_d", 32'(port_d), exp_d);
				check_value("hw_sel", 32'(hw_sel), exp_hw);
			end
		end
		$fclose(fd);

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire
